// ==== build.f ====
rtl/exu_pkg.sv
rtl/wb_pkg.sv
rtl/wb_req_filter.sv
rtl/wb_slot.sv
rtl/wb_arbiter.sv
rtl/wb_regfile.sv
rtl/wb_top.sv
verification/wb_checker.sv
verification/tb_wb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the write-back testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_wb_top -f build.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_wb_top > sim.log 2>&1
cat sim.log
grep -qx "ALL TESTS PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== verification/tb_wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_wb_top;

    localparam int N           = exu_pkg::NUM_SLOTS;
    localparam int AW          = wb_pkg::ADDR_W;
    localparam int DIR_CYCLES  = 60;
    localparam int RAND_CYCLES = 400;
    // twice the stimulus length, plus reset and drain margin
    localparam int TIMEOUT_CYCLES = 2 * (DIR_CYCLES + RAND_CYCLES) + 80;

    logic                      clk;
    logic                      rst_n;
    wb_pkg::wb_req_t           lsu_req;
    wb_pkg::wb_req_t           unit_req [N];
    wire [N-1:0]               unit_ready;
    wire wb_pkg::wb_commit_t   commit;
    logic [AW-1:0]             rd_addr;
    wire [wb_pkg::DATA_W-1:0]  rd_data;
    logic [AW-1:0]             rd_sweep;
    logic [wb_pkg::ID_W-1:0]   next_id;
    logic [31:0]               lfsr_state;
    int                        cycle_cnt;
    int                        err_commit;
    int                        err_ready;
    int                        err_read;

    wb_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_req_i    (lsu_req),
        .unit_req_i   (unit_req),
        .unit_ready_o (unit_ready),
        .commit_o     (commit),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data)
    );

    wb_checker i_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_req_i    (lsu_req),
        .unit_req_i   (unit_req),
        .unit_ready_i (unit_ready),
        .commit_i     (commit),
        .rd_addr_i    (rd_addr),
        .rd_data_i    (rd_data),
        .err_commit_o (err_commit),
        .err_ready_o  (err_ready),
        .err_read_o   (err_read)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic wb_pkg::wb_req_t make_req(input logic [AW-1:0] addr,
                                                 input logic [31:0] data);
        wb_pkg::wb_req_t req;
        req.valid     = 1'b1;
        req.we        = 1'b1;
        req.waddr     = addr;
        req.wdata     = data;
        req.commit_id = next_id;
        next_id       = next_id + 1'b1;
        return req;
    endfunction

    function automatic wb_pkg::wb_req_t rand_req();
        wb_pkg::wb_req_t req;
        req    = make_req(AW'(rand_bits(AW)), rand_bits(wb_pkg::DATA_W));
        req.we = (rand_bits(2) != 0);
        return req;
    endfunction

    // next cycle, inputs idle and the read port on the sweep address
    task automatic step_cycle();
        @(posedge clk);
        #1;
        lsu_req = '0;
        for (int i = 0; i < N; i++) begin
            unit_req[i] = '0;
        end
        rd_addr  = rd_sweep;
        rd_sweep = rd_sweep + 1'b1;
    endtask

    task automatic lone_write(input logic use_lsu, input exu_pkg::exu_unit_e u,
                              input logic [AW-1:0] addr, input logic [31:0] data);
        step_cycle();
        if (use_lsu)
            lsu_req = make_req(addr, data);
        else
            unit_req[u] = make_req(addr, data);
        step_cycle();
        rd_addr = addr;
    endtask

    task automatic wait_slots_empty();
        do begin
            step_cycle();
        end while (unit_ready !== '1);
    endtask

    initial begin
        rst_n      = 1'b0;
        lsu_req    = '0;
        for (int i = 0; i < N; i++) begin
            unit_req[i] = '0;
        end
        rd_addr    = '0;
        rd_sweep   = '0;
        next_id    = '0;
        lfsr_state = 32'hfb1edf1c;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset, read port sweeps every register
        repeat (32) step_cycle();

        lone_write(1'b0, exu_pkg::UNIT_MUL, 5'd1, 32'h1111_0001);
        lone_write(1'b0, exu_pkg::UNIT_DIV, 5'd2, 32'h2222_0002);
        lone_write(1'b0, exu_pkg::UNIT_CSR, 5'd3, 32'h3333_0003);
        lone_write(1'b0, exu_pkg::UNIT_ALU, 5'd4, 32'h4444_0004);
        lone_write(1'b1, exu_pkg::UNIT_MUL, 5'd9, 32'h1234_5678);

        // all units at once, then a fresh mul behind the buffered ones
        step_cycle();
        for (int i = 0; i < N; i++) begin
            unit_req[i] = make_req(AW'(10 + i), 32'hb000_0000 | i);
        end
        step_cycle();
        unit_req[exu_pkg::UNIT_MUL] = make_req(5'd14, 32'hb000_0010);
        wait_slots_empty();

        // load/store strobes hold every buffered result
        step_cycle();
        for (int i = 0; i < N; i++) begin
            unit_req[i] = make_req(AW'(16 + i), 32'hc000_0000 | i);
        end
        lsu_req = make_req(5'd20, 32'hc000_0100);
        for (int k = 1; k < 6; k++) begin
            step_cycle();
            lsu_req = make_req(AW'(20 + k), 32'hc000_0100 | k);
        end
        wait_slots_empty();

        // x0 targets commit without a write
        lone_write(1'b0, exu_pkg::UNIT_ALU, 5'd0, 32'hdead_beef);
        lone_write(1'b1, exu_pkg::UNIT_MUL, 5'd0, 32'hfeed_f00d);

        for (int c = 0; c < RAND_CYCLES; c++) begin
            step_cycle();
            if (rand_bits(2) == 0)
                lsu_req = rand_req();
            for (int i = 0; i < N; i++) begin
                if (unit_ready[i] && rand_bits(1) != 0)
                    unit_req[i] = rand_req();
            end
        end
        wait_slots_empty();
        step_cycle();
        @(negedge clk);
        #1;

        $display("errors: commit=%0d ready=%0d read=%0d", err_commit, err_ready, err_read);
        if (err_commit + err_ready + err_read == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/wb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_checker (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire wb_pkg::wb_req_t           lsu_req_i,
    input  wire wb_pkg::wb_req_t           unit_req_i [exu_pkg::NUM_SLOTS],
    input  wire [exu_pkg::NUM_SLOTS-1:0]   unit_ready_i,
    input  wire wb_pkg::wb_commit_t        commit_i,
    input  wire [wb_pkg::ADDR_W-1:0]       rd_addr_i,
    input  wire [wb_pkg::DATA_W-1:0]       rd_data_i,
    output int                             err_commit_o,
    output int                             err_ready_o,
    output int                             err_read_o
);

    localparam int N        = exu_pkg::NUM_SLOTS;
    localparam int LSU_WIN  = N;
    localparam int NUM_REGS = 2 ** wb_pkg::ADDR_W;

    logic [N-1:0]              mdl_full;
    wb_pkg::wb_req_t           mdl_hold [N];
    logic [wb_pkg::DATA_W-1:0] mdl_regs [NUM_REGS];
    wb_pkg::wb_req_t           cand [N];
    wb_pkg::wb_req_t           win_req;
    logic [N-1:0]              fresh;
    logic [wb_pkg::DATA_W-1:0] exp_rd;
    int                        win;
    int                        err_commit = 0;
    int                        err_ready = 0;
    int                        err_read = 0;

    assign err_commit_o = err_commit;
    assign err_ready_o  = err_ready;
    assign err_read_o   = err_read;

    // winner is LSU_WIN, a slot index, or -1 when nothing commits
    function automatic int pick_winner(input logic lsu_valid, input logic [N-1:0] full,
                                       input logic [N-1:0] fresh_valid);
        int sel;
        sel = -1;
        // scan from the low-priority end so the last hit wins
        for (int i = N - 1; i >= 0; i--) begin
            if (fresh_valid[i])
                sel = i;
        end
        for (int i = N - 1; i >= 0; i--) begin
            if (full[i])
                sel = i;
        end
        if (lsu_valid)
            sel = LSU_WIN;
        return sel;
    endfunction

    always @(negedge clk) begin
        if (!rst_n) begin
            mdl_full = '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                mdl_regs[r] = '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                fresh[i] = unit_req_i[i].valid && !mdl_full[i];
                cand[i]  = mdl_full[i] ? mdl_hold[i] : unit_req_i[i];
            end
            win     = pick_winner(lsu_req_i.valid, mdl_full, fresh);
            win_req = (win == LSU_WIN) ? lsu_req_i : '0;
            for (int i = 0; i < N; i++) begin
                if (win == i)
                    win_req = cand[i];
            end
            exp_rd = (rd_addr_i == '0) ? '0 : mdl_regs[rd_addr_i];

            if (commit_i.valid !== (win >= 0) ||
                (win >= 0 && commit_i.commit_id !== win_req.commit_id)) begin
                err_commit++;
                $display("MISMATCH t=%0t commit_o exp valid=%0b id=%0d got valid=%0b id=%0d",
                         $time, win >= 0, win_req.commit_id, commit_i.valid,
                         commit_i.commit_id);
            end
            if (unit_ready_i !== ~mdl_full) begin
                err_ready++;
                $display("MISMATCH t=%0t unit_ready_o exp=%b got=%b",
                         $time, ~mdl_full, unit_ready_i);
            end
            if (rd_data_i !== exp_rd) begin
                err_read++;
                $display("MISMATCH t=%0t rd_data_o x%0d exp=%h got=%h",
                         $time, rd_addr_i, exp_rd, rd_data_i);
            end

            // register write, slot drain and capture at the end of the cycle
            if (win >= 0 && win_req.we && win_req.waddr != '0)
                mdl_regs[win_req.waddr] = win_req.wdata;
            for (int i = 0; i < N; i++) begin
                if (mdl_full[i] && win == i) begin
                    mdl_full[i] = 1'b0;
                end else if (fresh[i] && win != i) begin
                    mdl_full[i] = 1'b1;
                    mdl_hold[i] = unit_req_i[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire wb_pkg::wb_req_t           lsu_req_i,
    input  wire wb_pkg::wb_req_t           unit_req_i [exu_pkg::NUM_SLOTS],
    output wire [exu_pkg::NUM_SLOTS-1:0]   unit_ready_o,
    output wb_pkg::wb_commit_t             commit_o,
    input  wire [wb_pkg::ADDR_W-1:0]       rd_addr_i,
    output wire [wb_pkg::DATA_W-1:0]       rd_data_o
);

    wire wb_pkg::wb_req_t          filt_req [exu_pkg::NUM_SLOTS];
    wire wb_pkg::wb_req_t          lsu_filt;
    wire wb_pkg::wb_req_t          cand_req [exu_pkg::NUM_SLOTS];
    wire [exu_pkg::NUM_SLOTS-1:0]  cand_buffered;
    wire [exu_pkg::NUM_SLOTS-1:0]  grant;
    wire                           wr_en;
    wire [wb_pkg::ADDR_W-1:0]      wr_addr;
    wire [wb_pkg::DATA_W-1:0]      wr_data;

    // a buffered slot is a full slot
    wb_req_filter i_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .unit_req_i  (unit_req_i),
        .lsu_req_i   (lsu_req_i),
        .slot_full_i (cand_buffered),
        .filt_req_o  (filt_req),
        .lsu_filt_o  (lsu_filt)
    );

    for (genvar i = 0; i < exu_pkg::NUM_SLOTS; i++) begin : g_slot
        wb_slot i_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_i      (filt_req[i]),
            .grant_i    (grant[i]),
            .cand_o     (cand_req[i]),
            .buffered_o (cand_buffered[i]),
            .ready_o    (unit_ready_o[i])
        );
    end

    wb_arbiter i_arbiter (
        .lsu_i      (lsu_filt),
        .cand_i     (cand_req),
        .buffered_i (cand_buffered),
        .grant_o    (grant),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .commit_o   (commit_o)
    );

    wb_regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// ==== rtl/wb_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_regfile (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wr_en_i,
    input  wire [wb_pkg::ADDR_W-1:0]   wr_addr_i,
    input  wire [wb_pkg::DATA_W-1:0]   wr_data_i,
    input  wire [wb_pkg::ADDR_W-1:0]   rd_addr_i,
    output logic [wb_pkg::DATA_W-1:0]  rd_data_o
);

    localparam int NUM_REGS = 2 ** wb_pkg::ADDR_W;

    logic [wb_pkg::DATA_W-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 always reads zero
    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs_q[rd_addr_i];

    // the request filter strips x0 writes upstream
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_i |-> (wr_addr_i != '0))
        else $error("wb_regfile: write enable with address x0");

endmodule

`default_nettype wire

// ==== rtl/wb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  wire wb_pkg::wb_req_t           lsu_i,
    input  wire wb_pkg::wb_req_t           cand_i [exu_pkg::NUM_SLOTS],
    input  wire [exu_pkg::NUM_SLOTS-1:0]   buffered_i,
    output logic [exu_pkg::NUM_SLOTS-1:0]  grant_o,
    output logic                           wr_en_o,
    output logic [wb_pkg::ADDR_W-1:0]      wr_addr_o,
    output logic [wb_pkg::DATA_W-1:0]      wr_data_o,
    output wb_pkg::wb_commit_t             commit_o
);

    localparam int REQ_W = $bits(wb_pkg::wb_req_t);

    logic            found;
    wb_pkg::wb_req_t sel_req;

    // lsu first, then held results, then fresh ones, each group in unit order
    always_comb begin
        grant_o = '0;
        found   = lsu_i.valid;
        for (int i = 0; i < exu_pkg::NUM_SLOTS; i++) begin
            if (!found && buffered_i[i] && cand_i[i].valid) begin
                grant_o[i] = 1'b1;
                found      = 1'b1;
            end
        end
        // fresh results only get through when nothing is waiting
        for (int i = 0; i < exu_pkg::NUM_SLOTS; i++) begin
            if (!found && !buffered_i[i] && cand_i[i].valid) begin
                grant_o[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    // and-or select of the winner
    always_comb begin
        sel_req = {REQ_W{lsu_i.valid}} & lsu_i;
        for (int i = 0; i < exu_pkg::NUM_SLOTS; i++) begin
            sel_req = sel_req | ({REQ_W{grant_o[i]}} & cand_i[i]);
        end
    end

    assign wr_en_o            = sel_req.valid & sel_req.we;
    assign wr_addr_o          = sel_req.waddr;
    assign wr_data_o          = sel_req.wdata;
    assign commit_o.valid     = sel_req.valid;
    assign commit_o.commit_id = sel_req.commit_id;

    // at most one slot drains per cycle
    always_comb begin
        a_grant_onehot: assert ($onehot0(grant_o))
            else $error("wb_arbiter: grant not one-hot: %b", grant_o);
    end

endmodule

`default_nettype wire

// ==== rtl/wb_slot.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_slot (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire wb_pkg::wb_req_t req_i,
    input  wire                  grant_i,
    output wb_pkg::wb_req_t      cand_o,
    output logic                 buffered_o,
    output logic                 ready_o
);

    logic            full_q;
    wb_pkg::wb_req_t hold_q;
    logic            capture;

    // a fresh result that lost arbitration this cycle
    assign capture = !full_q && req_i.valid && !grant_i;

    // held entry goes ahead of anything new
    assign cand_o     = full_q ? hold_q : req_i;
    assign buffered_o = full_q;
    assign ready_o    = !full_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (full_q) begin
            // drained once the arbiter picks it
            if (grant_i) begin
                full_q <= 1'b0;
            end
        end else if (capture) begin
            full_q <= 1'b1;
        end
    end

    // losing result parked until its turn
    always_ff @(posedge clk) begin
        if (capture) begin
            hold_q <= req_i;
        end
    end

    // the arbiter may only grant a slot that presents a valid candidate
    a_grant_has_cand: assert property (@(posedge clk) disable iff (!rst_n)
        grant_i |-> cand_o.valid)
        else $error("wb_slot: grant without a valid candidate");

endmodule

`default_nettype wire

// ==== rtl/wb_req_filter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_req_filter (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire wb_pkg::wb_req_t            unit_req_i [exu_pkg::NUM_SLOTS],
    input  wire wb_pkg::wb_req_t            lsu_req_i,
    input  wire [exu_pkg::NUM_SLOTS-1:0]    slot_full_i,
    output wb_pkg::wb_req_t                 filt_req_o [exu_pkg::NUM_SLOTS],
    output wb_pkg::wb_req_t                 lsu_filt_o
);

    // a write to x0 keeps its commit but loses the register write
    function automatic wb_pkg::wb_req_t filter_req(input wb_pkg::wb_req_t req,
                                                   input logic accept);
        wb_pkg::wb_req_t res;
        res       = req;
        res.valid = req.valid & accept;
        res.we    = res.valid & req.we & (req.waddr != '0);
        return res;
    endfunction

    // load/store has no back-pressure
    assign lsu_filt_o = filter_req(lsu_req_i, 1'b1);

    for (genvar i = 0; i < exu_pkg::NUM_SLOTS; i++) begin : g_unit
        // a full slot cannot take another result
        assign filt_req_o[i] = filter_req(unit_req_i[i], !slot_full_i[i]);

        // units must respect ready, otherwise a result would be dropped here
        a_no_req_when_full: assert property (@(posedge clk) disable iff (!rst_n)
            unit_req_i[i].valid |-> !slot_full_i[i])
            else $error("wb_req_filter: unit %0d valid while its slot is full", i);
    end

endmodule

`default_nettype wire

// ==== rtl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;
    localparam int ID_W   = 3;

    // one finished result on its way to the register file
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] waddr;
        logic [DATA_W-1:0] wdata;
        logic [ID_W-1:0]   commit_id;
    } wb_req_t;

    // retirement report
    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] commit_id;
    } wb_commit_t;

endpackage

`default_nettype wire

// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // stallable execution units, highest priority first
    typedef enum logic [1:0] {
        UNIT_MUL = 2'd0,
        UNIT_DIV = 2'd1,
        UNIT_CSR = 2'd2,
        UNIT_ALU = 2'd3
    } exu_unit_e;

    // one holding slot per stallable unit
    localparam int NUM_SLOTS = int'(UNIT_ALU) + 1;

endpackage

`default_nettype wire
